// ==== Bender.yml ====
package:
  name: rv32_core

sources:
  - rtl/rv_pkg.sv
  - rtl/pipe_ifs.sv
  - rtl/fetch_stage.sv
  - rtl/decode_stage.sv
  - rtl/execute_stage.sv
  - rtl/memory_stage.sv
  - rtl/rv32_core.sv
  - target: test
    files:
      - verif/tb_rv32_core.sv

// ==== rtl/decode_stage.sv ====
`timescale 1ns/100ps

module decode_stage import rv_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       if_valid,
    input  word_t      if_pc,
    input  word_t      if_instr,
    input  logic       redirect,
    input  logic       mem_busy,
    output logic       load_use_stall,
    id_ex_if.producer  id_ex,
    mem_wb_if.consumer wb
);
    word_t      regs [num_regs];
    opcode_e    opcode;
    logic [2:0] funct3;
    logic       funct7_5;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      rs1_val;
    word_t      rs2_val;
    logic       wb_write;

    alu_op_e    alu_op;
    word_t      imm;
    logic       use_imm;
    logic       reg_we;
    logic       mem_re;
    logic       mem_we;
    logic       is_branch;
    logic       uses_rs1;
    logic       uses_rs2;

    assign opcode   = opcode_e'(if_instr[6:0]);
    assign funct3   = if_instr[14:12];
    assign funct7_5 = if_instr[30];
    assign rs1      = if_instr[19:15];
    assign rs2      = if_instr[24:20];
    assign rd       = if_instr[11:7];

    assign imm_i = {{20{if_instr[31]}}, if_instr[31:20]};
    assign imm_s = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
    assign imm_b = {{19{if_instr[31]}}, if_instr[31], if_instr[7], if_instr[30:25],
                    if_instr[11:8], 1'b0};
    assign imm_u = {if_instr[31:12], 12'h000};

    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  arith_op = alt ? alu_sub : alu_add;
            3'b001:  arith_op = alu_sll;
            3'b010:  arith_op = alu_slt;
            3'b011:  arith_op = alu_sltu;
            3'b100:  arith_op = alu_xor;
            3'b101:  arith_op = alt ? alu_sra : alu_srl;
            3'b110:  arith_op = alu_or;
            default: arith_op = alu_and;
        endcase
    endfunction

    // Unknown opcodes fall out as no-ops
    always_comb begin
        alu_op    = alu_add;
        imm       = imm_i;
        use_imm   = 1'b0;
        reg_we    = 1'b0;
        mem_re    = 1'b0;
        mem_we    = 1'b0;
        is_branch = 1'b0;
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        case (opcode)
            op: begin
                alu_op   = arith_op(funct3, funct7_5);
                reg_we   = 1'b1;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            op_imm: begin
                alu_op   = arith_op(funct3, funct7_5 && funct3 == 3'b101);
                use_imm  = 1'b1;
                reg_we   = 1'b1;
                uses_rs1 = 1'b1;
            end
            lui: begin
                alu_op  = alu_pass_b;
                imm     = imm_u;
                use_imm = 1'b1;
                reg_we  = 1'b1;
            end
            load: begin
                use_imm  = 1'b1;
                reg_we   = 1'b1;
                mem_re   = 1'b1;
                uses_rs1 = 1'b1;
            end
            store: begin
                imm      = imm_s;
                use_imm  = 1'b1;
                mem_we   = 1'b1;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            branch: begin
                // BEQ and BNE only
                if (funct3[2:1] == 2'b00) begin
                    alu_op    = alu_sub;
                    imm       = imm_b;
                    is_branch = 1'b1;
                    uses_rs1  = 1'b1;
                    uses_rs2  = 1'b1;
                end
            end
            default: begin
            end
        endcase
    end

    assign wb_write = wb.valid && wb.reg_we && wb.rd != '0;

    always_ff @(posedge clk) begin
        if (wb_write) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // Write-through read with x0 hardwired to zero
    function automatic word_t read_reg(input reg_idx_t idx);
        if (idx == '0) begin
            read_reg = '0;
        end else if (wb_write && wb.rd == idx) begin
            read_reg = wb.data;
        end else begin
            read_reg = regs[idx];
        end
    endfunction

    always_comb begin
        rs1_val = read_reg(rs1);
        rs2_val = read_reg(rs2);
    end

    assign load_use_stall = if_valid && id_ex.valid && id_ex.mem_re && id_ex.reg_we &&
                            ((uses_rs1 && rs1 == id_ex.rd) || (uses_rs2 && rs2 == id_ex.rd));

    always_ff @(posedge clk) begin
        if (reset || redirect) begin
            id_ex.valid <= 1'b0;
        end else if (!mem_busy) begin
            id_ex.valid <= if_valid && !load_use_stall;
        end
    end

    always_ff @(posedge clk) begin
        if (!mem_busy) begin
            id_ex.pc        <= if_pc;
            id_ex.alu_op    <= alu_op;
            id_ex.use_imm   <= use_imm;
            id_ex.imm       <= imm;
            id_ex.rs1       <= rs1;
            id_ex.rs2       <= rs2;
            id_ex.rs1_val   <= rs1_val;
            id_ex.rs2_val   <= rs2_val;
            id_ex.rd        <= rd;
            id_ex.reg_we    <= reg_we && rd != '0;
            id_ex.mem_re    <= mem_re;
            id_ex.mem_we    <= mem_we;
            id_ex.is_branch <= is_branch;
            id_ex.branch_ne <= funct3[0];
        end else begin
            // Held operands pick up writebacks that retire during the stall
            if (wb_write && wb.rd == id_ex.rs1) begin
                id_ex.rs1_val <= wb.data;
            end
            if (wb_write && wb.rd == id_ex.rs2) begin
                id_ex.rs2_val <= wb.data;
            end
        end
    end

    a_no_x0_write: assert property (@(posedge clk) disable iff (reset)
        !(wb.valid && wb.reg_we && wb.rd == '0));

endmodule

// ==== rtl/execute_stage.sv ====
`timescale 1ns/100ps

module execute_stage import rv_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       mem_busy,
    id_ex_if.consumer  id_ex,
    ex_mem_if.producer ex_mem,
    mem_wb_if.consumer wb,
    output logic       redirect,
    output word_t      redirect_pc
);
    word_t op_a;
    word_t op_b_reg;
    word_t op_b;
    word_t alu_result;
    logic  taken;

    // Youngest writer wins; a load in MEM has no data yet
    function automatic word_t forward(input reg_idx_t idx, input word_t reg_val);
        if (idx == '0) begin
            forward = reg_val;
        end else if (ex_mem.valid && ex_mem.reg_we && !ex_mem.mem_re && ex_mem.rd == idx) begin
            forward = ex_mem.result;
        end else if (wb.valid && wb.reg_we && wb.rd == idx) begin
            forward = wb.data;
        end else begin
            forward = reg_val;
        end
    endfunction

    always_comb begin
        op_a     = forward(id_ex.rs1, id_ex.rs1_val);
        op_b_reg = forward(id_ex.rs2, id_ex.rs2_val);
        op_b     = id_ex.use_imm ? id_ex.imm : op_b_reg;
    end

    always_comb begin
        case (id_ex.alu_op)
            alu_add:    alu_result = op_a + op_b;
            alu_sub:    alu_result = op_a - op_b;
            alu_and:    alu_result = op_a & op_b;
            alu_or:     alu_result = op_a | op_b;
            alu_xor:    alu_result = op_a ^ op_b;
            alu_slt:    alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
            alu_sltu:   alu_result = {31'd0, op_a < op_b};
            alu_sll:    alu_result = op_a << op_b[4:0];
            alu_srl:    alu_result = op_a >> op_b[4:0];
            alu_sra:    alu_result = $signed(op_a) >>> op_b[4:0];
            alu_pass_b: alu_result = op_b;
            default:    alu_result = op_a + op_b;
        endcase
    end

    // BEQ/BNE on the forwarded register operands
    assign taken       = (op_a == op_b_reg) ^ id_ex.branch_ne;
    assign redirect    = id_ex.valid && id_ex.is_branch && taken && !mem_busy;
    assign redirect_pc = id_ex.pc + id_ex.imm;

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_mem.valid <= 1'b0;
        end else if (!mem_busy) begin
            ex_mem.valid <= id_ex.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!mem_busy) begin
            ex_mem.rd         <= id_ex.rd;
            ex_mem.reg_we     <= id_ex.reg_we;
            ex_mem.mem_re     <= id_ex.mem_re;
            ex_mem.mem_we     <= id_ex.mem_we;
            ex_mem.result     <= alu_result;
            ex_mem.store_data <= op_b_reg;
        end
    end

    // The slot behind a taken branch must come back empty from decode
    a_redirect_flush: assert property (@(posedge clk) disable iff (reset)
        redirect |=> !id_ex.valid);

endmodule

// ==== rtl/fetch_stage.sv ====
`timescale 1ns/100ps

module fetch_stage import rv_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  redirect,
    input  word_t redirect_pc,
    input  logic  hold,
    output word_t imem_addr,
    input  word_t imem_data,
    output logic  if_valid,
    output word_t if_pc,
    output word_t if_instr
);
    word_t pc;
    word_t next_pc;

    // Redirect beats hold
    always_comb begin
        if (redirect) begin
            next_pc = redirect_pc;
        end else if (hold) begin
            next_pc = pc;
        end else begin
            next_pc = pc + instr_bytes;
        end
    end

    assign imem_addr = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= reset_pc;
            if_valid <= 1'b0;
        end else begin
            pc <= next_pc;
            if (redirect) begin
                if_valid <= 1'b0;
            end else if (!hold) begin
                if_valid <= 1'b1;
            end
        end
    end

    // IF/ID payload
    always_ff @(posedge clk) begin
        if (!hold && !redirect) begin
            if_pc    <= pc;
            if_instr <= imem_data;
        end
    end

endmodule

// ==== rtl/memory_stage.sv ====
`timescale 1ns/100ps

module memory_stage import rv_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    ex_mem_if.consumer ex_mem,
    output logic       mem_busy,
    output logic       dmem_req,
    output logic       dmem_we,
    output word_t      dmem_addr,
    output word_t      dmem_wdata,
    input  logic       dmem_ack,
    input  word_t      dmem_rdata,
    mem_wb_if.producer wb
);
    typedef enum logic [1:0] {
        idle,
        wait_ack_high,
        wait_ack_low
    } dmem_state_e;

    dmem_state_e state;
    logic        access;
    word_t       load_data;
    wb_sel_e     wb_sel;

    assign access   = ex_mem.valid && (ex_mem.mem_re || ex_mem.mem_we);
    // Busy until the cycle the responder drops ack
    assign mem_busy = access && !(state == wait_ack_low && !dmem_ack);

    assign dmem_req   = (state == wait_ack_high);
    assign dmem_we    = ex_mem.mem_we;
    assign dmem_addr  = ex_mem.result;
    assign dmem_wdata = ex_mem.store_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (access && !dmem_ack) begin
                        state <= wait_ack_high;
                    end
                end
                wait_ack_high: begin
                    if (dmem_ack) begin
                        state <= wait_ack_low;
                    end
                end
                wait_ack_low: begin
                    if (!dmem_ack) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == wait_ack_high && dmem_ack) begin
            load_data <= dmem_rdata;
        end
    end

    assign wb_sel = ex_mem.mem_re ? wb_load : wb_alu;

    // Bubbles while the port is busy, so nothing retires twice
    always_ff @(posedge clk) begin
        if (reset) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= ex_mem.valid && !mem_busy;
        end
    end

    always_ff @(posedge clk) begin
        wb.rd     <= ex_mem.rd;
        wb.reg_we <= ex_mem.reg_we;
        wb.data   <= (wb_sel == wb_load) ? load_data : ex_mem.result;
    end

    a_req_until_ack: assert property (@(posedge clk) disable iff (reset)
        dmem_req && !dmem_ack |=> dmem_req);

    a_addr_stable: assert property (@(posedge clk) disable iff (reset)
        dmem_req |=> !dmem_req || ($stable(dmem_addr) && $stable(dmem_we) &&
                                   $stable(dmem_wdata)));

    a_no_req_on_ack: assert property (@(posedge clk) disable iff (reset)
        !dmem_req && dmem_ack |=> !dmem_req);

endmodule

// ==== rtl/pipe_ifs.sv ====
`timescale 1ns/100ps

// Decode to execute
interface id_ex_if import rv_pkg::*; ();
    logic     valid;
    word_t    pc;
    alu_op_e  alu_op;
    logic     use_imm;
    word_t    imm;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    rs1_val;
    word_t    rs2_val;
    reg_idx_t rd;
    logic     reg_we;
    logic     mem_re;
    logic     mem_we;
    logic     is_branch;
    logic     branch_ne;

    modport producer (output valid, pc, alu_op, use_imm, imm, rs1, rs2, rs1_val, rs2_val,
                      rd, reg_we, mem_re, mem_we, is_branch, branch_ne);
    modport consumer (input valid, pc, alu_op, use_imm, imm, rs1, rs2, rs1_val, rs2_val,
                      rd, reg_we, mem_re, mem_we, is_branch, branch_ne);
endinterface

// Execute to memory
interface ex_mem_if import rv_pkg::*; ();
    logic     valid;
    reg_idx_t rd;
    logic     reg_we;
    logic     mem_re;
    logic     mem_we;
    word_t    result;
    word_t    store_data;

    modport producer (output valid, rd, reg_we, mem_re, mem_we, result, store_data);
    modport consumer (input valid, rd, reg_we, mem_re, mem_we, result, store_data);
endinterface

// Memory to writeback and the retire view
interface mem_wb_if import rv_pkg::*; ();
    logic     valid;
    reg_idx_t rd;
    logic     reg_we;
    word_t    data;

    modport producer (output valid, rd, reg_we, data);
    modport consumer (input valid, rd, reg_we, data);
endinterface

// ==== rtl/rv32_core.sv ====
`timescale 1ns/100ps

module rv32_core import rv_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    output word_t    imem_addr,
    input  word_t    imem_data,
    output logic     dmem_req,
    output logic     dmem_we,
    output word_t    dmem_addr,
    output word_t    dmem_wdata,
    input  logic     dmem_ack,
    input  word_t    dmem_rdata,
    output logic     retire_valid,
    output logic     retire_we,
    output reg_idx_t retire_rd,
    output word_t    retire_data
);
    logic  redirect;
    word_t redirect_pc;
    logic  load_use_stall;
    logic  mem_busy;
    logic  fetch_hold;
    logic  if_valid;
    word_t if_pc;
    word_t if_instr;

    id_ex_if  id_ex ();
    ex_mem_if ex_mem ();
    mem_wb_if mem_wb ();

    assign fetch_hold = load_use_stall || mem_busy;

    fetch_stage i_fetch (
        .clk         (clk),
        .reset       (reset),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .hold        (fetch_hold),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .if_valid    (if_valid),
        .if_pc       (if_pc),
        .if_instr    (if_instr)
    );

    decode_stage i_decode (
        .clk            (clk),
        .reset          (reset),
        .if_valid       (if_valid),
        .if_pc          (if_pc),
        .if_instr       (if_instr),
        .redirect       (redirect),
        .mem_busy       (mem_busy),
        .load_use_stall (load_use_stall),
        .id_ex          (id_ex.producer),
        .wb             (mem_wb.consumer)
    );

    execute_stage i_execute (
        .clk         (clk),
        .reset       (reset),
        .mem_busy    (mem_busy),
        .id_ex       (id_ex.consumer),
        .ex_mem      (ex_mem.producer),
        .wb          (mem_wb.consumer),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    memory_stage i_memory (
        .clk        (clk),
        .reset      (reset),
        .ex_mem     (ex_mem.consumer),
        .mem_busy   (mem_busy),
        .dmem_req   (dmem_req),
        .dmem_we    (dmem_we),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_ack   (dmem_ack),
        .dmem_rdata (dmem_rdata),
        .wb         (mem_wb.producer)
    );

    assign retire_valid = mem_wb.valid;
    assign retire_we    = mem_wb.reg_we;
    assign retire_rd    = mem_wb.rd;
    assign retire_data  = mem_wb.data;

endmodule

// ==== rtl/rv_pkg.sv ====
package rv_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;
    localparam int num_regs = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [reg_addr_w-1:0] reg_idx_t;

    localparam word_t reset_pc = 32'h0000_0000;
    localparam word_t instr_bytes = 32'd4;

    // RV32I major opcodes kept by this core
    typedef enum logic [6:0] {
        op     = 7'b0110011,
        op_imm = 7'b0010011,
        lui    = 7'b0110111,
        load   = 7'b0000011,
        store  = 7'b0100011,
        branch = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_slt    = 4'd5,
        alu_sltu   = 4'd6,
        alu_sll    = 4'd7,
        alu_srl    = 4'd8,
        alu_sra    = 4'd9,
        alu_pass_b = 4'd10
    } alu_op_e;

    typedef enum logic {
        wb_alu  = 1'b0,
        wb_load = 1'b1
    } wb_sel_e;

endpackage

// ==== sources.f ====
rtl/rv_pkg.sv
rtl/pipe_ifs.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/rv32_core.sv
verif/tb_rv32_core.sv

// ==== verif/program.hex ====
// One RV32I instruction word per line, loaded from address 0
// Comments give the assembly of each word
123450B7 // lui  x1, 0x12345
06400113 // addi x2, x0, 100
FF910193 // addi x3, x2, -7
00310233 // add  x4, x2, x3
401202B3 // sub  x5, x4, x1
0012F333 // and  x6, x5, x1
003363B3 // or   x7, x6, x3
00311413 // slli x8, x2, 3
4022D4B3 // sra  x9, x5, x2
0082D593 // srli x11, x5, 8
0022A633 // slt  x12, x5, x2
0022B6B3 // sltu x13, x5, x2
03710013 // addi x0, x2, 55
00200733 // add  x14, x0, x2
10000513 // addi x10, x0, 0x100
00452023 // sw   x4, 0(x10)
00952223 // sw   x9, 4(x10)
00052783 // lw   x15, 0(x10)
00F78833 // add  x16, x15, x15
00852883 // lw   x17, 8(x10)
0108C933 // xor  x18, x17, x16
00097A13 // andi x20, x18, 0
00300993 // addi x19, x0, 3
005A0A13 // addi x20, x20, 5
FFF98993 // addi x19, x19, -1
FE099CE3 // bne  x19, x0, -8
00EA0463 // beq  x20, x14, +8
00098463 // beq  x19, x0, +8
06300A93 // addi x21, x0, 99
01452623 // sw   x20, 12(x10)
00000063 // beq  x0, x0, 0
00100B93 // addi x23, x0, 1

// ==== verif/tb_rv32_core.sv ====
`timescale 1ns/100ps

module tb_rv32_core import rv_pkg::*; ();
    localparam int clk_period = 4;
    localparam int reset_cycles = 8;
    localparam int imem_words = 64;
    localparam int dmem_words = 256;
    localparam int max_steps = 256;

    logic     clk;
    logic     reset;
    word_t    imem_addr;
    word_t    imem_data;
    logic     dmem_req;
    logic     dmem_we;
    word_t    dmem_addr;
    word_t    dmem_wdata;
    logic     dmem_ack;
    word_t    dmem_rdata;
    logic     retire_valid;
    logic     retire_we;
    reg_idx_t retire_rd;
    word_t    retire_data;

    word_t    imem [imem_words];
    word_t    dmem [dmem_words];
    word_t    model_regs [num_regs];
    word_t    model_mem [dmem_words];

    // Expected retire stream and data-port accesses, in order
    logic     exp_we [max_steps];
    reg_idx_t exp_rd [max_steps];
    word_t    exp_data [max_steps];
    logic     acc_we [max_steps];
    word_t    acc_addr [max_steps];
    word_t    acc_wdata [max_steps];
    int       exp_count;
    int       acc_count;
    int       ret_idx;
    int       acc_idx;
    logic     req_q;
    logic     model_ready;

    logic     exp_we_now;
    reg_idx_t exp_rd_now;
    word_t    exp_data_now;
    logic     acc_we_now;
    word_t    acc_addr_now;
    word_t    acc_wdata_now;
    logic     retire_ok;
    logic     access_ok;

    rv32_core i_dut (
        .clk          (clk),
        .reset        (reset),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .dmem_req     (dmem_req),
        .dmem_we      (dmem_we),
        .dmem_addr    (dmem_addr),
        .dmem_wdata   (dmem_wdata),
        .dmem_ack     (dmem_ack),
        .dmem_rdata   (dmem_rdata),
        .retire_valid (retire_valid),
        .retire_we    (retire_we),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    assign imem_data = imem[imem_addr[7:2]];

    function automatic word_t mem_fill(input word_t addr);
        mem_fill = (addr * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
    endfunction

    // RV32I arithmetic semantics by funct3
    function automatic word_t ref_alu(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        case (f3)
            3'd0: ref_alu = alt ? a - b : a + b;
            3'd1: ref_alu = a << b[4:0];
            3'd2: ref_alu = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: ref_alu = (a < b) ? 32'd1 : 32'd0;
            3'd4: ref_alu = a ^ b;
            3'd5: begin
                if (alt) begin
                    ref_alu = $signed(a) >>> b[4:0];
                end else begin
                    ref_alu = a >> b[4:0];
                end
            end
            3'd6: ref_alu = a | b;
            default: ref_alu = a & b;
        endcase
    endfunction

    // In-order model that stops at the branch to itself
    task automatic build_expected();
        word_t      pc;
        word_t      instr;
        word_t      a;
        word_t      b;
        word_t      val;
        word_t      addr;
        word_t      imm_i;
        word_t      imm_s;
        word_t      imm_b;
        reg_idx_t   rd;
        logic [2:0] f3;
        logic       writes;
        logic       finished;
        pc = reset_pc;
        exp_count = 0;
        acc_count = 0;
        finished = 1'b0;
        for (int i = 0; i < num_regs; i++) begin
            model_regs[i] = '0;
        end
        while (!finished && exp_count < max_steps) begin
            instr = imem[pc[7:2]];
            rd = instr[11:7];
            f3 = instr[14:12];
            a = model_regs[instr[19:15]];
            b = model_regs[instr[24:20]];
            imm_i = {{20{instr[31]}}, instr[31:20]};
            imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            writes = 1'b0;
            val = '0;
            case (opcode_e'(instr[6:0]))
                op: begin
                    val = ref_alu(f3, instr[30], a, b);
                    writes = 1'b1;
                end
                op_imm: begin
                    val = ref_alu(f3, instr[30] && f3 == 3'd5, a, imm_i);
                    writes = 1'b1;
                end
                lui: begin
                    val = {instr[31:12], 12'h000};
                    writes = 1'b1;
                end
                load: begin
                    addr = a + imm_i;
                    val = model_mem[addr[9:2]];
                    writes = 1'b1;
                    acc_we[acc_count] = 1'b0;
                    acc_addr[acc_count] = addr;
                    acc_wdata[acc_count] = '0;
                    acc_count++;
                end
                store: begin
                    addr = a + imm_s;
                    model_mem[addr[9:2]] = b;
                    acc_we[acc_count] = 1'b1;
                    acc_addr[acc_count] = addr;
                    acc_wdata[acc_count] = b;
                    acc_count++;
                end
                branch: begin
                    if (f3[2:1] == 2'b00 && ((a == b) ^ f3[0])) begin
                        finished = (imm_b == '0);
                        pc = pc + imm_b - instr_bytes;
                    end
                end
                default: begin
                end
            endcase
            exp_we[exp_count] = writes && rd != '0;
            exp_rd[exp_count] = rd;
            exp_data[exp_count] = val;
            exp_count++;
            if (writes && rd != '0) begin
                model_regs[rd] = val;
            end
            pc = pc + instr_bytes;
        end
    endtask

    task automatic stop_with_failure();
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_failure(input string msg);
        $display("[FAIL] %0t %s", $time, msg);
        stop_with_failure();
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        void'($urandom(32'h3c6));
        reset = 1'b1;
        dmem_ack = 1'b0;
        dmem_rdata = '0;
        model_ready = 1'b0;
        for (int i = 0; i < imem_words; i++) begin
            imem[i] = 32'h0000_0013;
        end
        $readmemh("verif/program.hex", imem);
        for (int i = 0; i < dmem_words; i++) begin
            dmem[i] = mem_fill(i * 4);
            model_mem[i] = mem_fill(i * 4);
        end
        build_expected();
        model_ready = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1 reset = 1'b0;
    end

    // Four-phase responder with random delays on both ack edges
    initial begin
        forever begin
            @(posedge clk);
            #1;
            if (dmem_req && !dmem_ack) begin
                wait_cycles($urandom_range(3, 0));
                if (dmem_we) begin
                    dmem[dmem_addr[9:2]] = dmem_wdata;
                end else begin
                    dmem_rdata = dmem[dmem_addr[9:2]];
                end
                dmem_ack = 1'b1;
                while (dmem_req) begin
                    @(posedge clk);
                    #1;
                end
                wait_cycles($urandom_range(3, 0));
                dmem_ack = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            ret_idx <= 0;
            acc_idx <= 0;
            req_q   <= 1'b0;
        end else begin
            req_q <= dmem_req;
            if (retire_valid) begin
                ret_idx <= ret_idx + 1;
            end
            if (dmem_req && !req_q) begin
                acc_idx <= acc_idx + 1;
            end
        end
    end

    always_comb begin
        exp_we_now = 1'b0;
        exp_rd_now = '0;
        exp_data_now = '0;
        acc_we_now = 1'b0;
        acc_addr_now = '0;
        acc_wdata_now = '0;
        if (ret_idx < exp_count) begin
            exp_we_now = exp_we[ret_idx];
            exp_rd_now = exp_rd[ret_idx];
            exp_data_now = exp_data[ret_idx];
        end
        if (acc_idx < acc_count) begin
            acc_we_now = acc_we[acc_idx];
            acc_addr_now = acc_addr[acc_idx];
            acc_wdata_now = acc_wdata[acc_idx];
        end
    end

    assign retire_ok = ret_idx < exp_count && retire_we == exp_we_now &&
                       (!retire_we || (retire_rd == exp_rd_now && retire_data == exp_data_now));
    assign access_ok = acc_idx < acc_count && dmem_we == acc_we_now &&
                       dmem_addr == acc_addr_now && (!dmem_we || dmem_wdata == acc_wdata_now);

    a_reset_release: assert property (@(posedge clk) $fell(reset) |->
        imem_addr == reset_pc && !retire_valid && !dmem_req)
        else report_failure("fetch address or outputs wrong at reset release");

    a_quiet_start: assert property (@(posedge clk) disable iff (reset)
        ret_idx == 0 |-> !dmem_req)
        else report_failure("data request before the first retire");

    a_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(retire_valid) && !$isunknown(dmem_req))
        else report_failure("retire_valid or dmem_req unknown");

    a_retire_match: assert property (@(posedge clk) disable iff (reset)
        retire_valid |-> retire_ok)
        else report_failure($sformatf(
            "retire %0d got we=%b rd=%0d data=%h, exp we=%b rd=%0d data=%h",
            $sampled(ret_idx), $sampled(retire_we), $sampled(retire_rd), $sampled(retire_data),
            $sampled(exp_we_now), $sampled(exp_rd_now), $sampled(exp_data_now)));

    a_access_match: assert property (@(posedge clk) disable iff (reset)
        $rose(dmem_req) |-> access_ok)
        else report_failure($sformatf(
            "access %0d got we=%b addr=%h wdata=%h, exp we=%b addr=%h wdata=%h",
            $sampled(acc_idx), $sampled(dmem_we), $sampled(dmem_addr),
            $sampled(dmem_wdata), $sampled(acc_we_now), $sampled(acc_addr_now),
            $sampled(acc_wdata_now)));

    // Handshake order seen from the port
    a_req_after_ack_low: assert property (@(posedge clk) disable iff (reset)
        $rose(dmem_req) |-> !$past(dmem_ack))
        else report_failure("request raised while ack was high");

    a_req_drops_on_ack: assert property (@(posedge clk) disable iff (reset)
        dmem_req && dmem_ack |=> !dmem_req)
        else report_failure("request not lowered after ack");

    initial begin
        wait (model_ready);
        wait (ret_idx == exp_count);
        // Discarded slots behind the final branch would surface in these two cycles
        repeat (2) @(posedge clk);
        @(negedge clk);
        if (acc_idx == acc_count) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("Only %0d of %0d data accesses were seen", acc_idx, acc_count);
            stop_with_failure();
        end
    end

    initial begin
        wait (model_ready);
        #((exp_count * 40 + reset_cycles + 4) * clk_period);
        $display("Timeout: program did not reach its final branch, %0d of %0d retired",
                 ret_idx, exp_count);
        stop_with_failure();
    end

endmodule
